//--- Makefile
TOP = tb_axi_slave_subsystem

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module $(TOP) -Mdir obj_dir

run: compile
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir

//--- flist.f
+incdir+hdl
hdl/axi_slave_pkg.sv
hdl/axi_address_decode.sv
hdl/axi_register_bank.sv
hdl/axi_terminator.sv
hdl/axi_response_mux.sv
hdl/axi_slave_subsystem.sv
tb/tb_axi_slave_subsystem.sv

//--- hdl/axi_address_decode.sv
/* Address decode for the slave endpoint. Steers AW, AR and W to the register bank or
   the terminator and holds each direction's target until its response completes. */
`timescale 1ns/1ps
`default_nettype none

`include "axi_slave_config.svh"

module axi_address_decode (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       aw_valid,
    input  logic [`AXI_ADDR_WIDTH-1:0] aw_addr,
    output logic                       aw_ready,
    input  logic                       ar_valid,
    input  logic [`AXI_ADDR_WIDTH-1:0] ar_addr,
    output logic                       ar_ready,
    output logic                       reg_aw_valid,
    output logic                       term_aw_valid,
    input  logic                       reg_aw_ready,
    input  logic                       term_aw_ready,
    output logic                       reg_ar_valid,
    output logic                       term_ar_valid,
    input  logic                       reg_ar_ready,
    input  logic                       term_ar_ready,
    input  logic                       w_valid,
    output logic                       reg_w_valid,
    output logic                       term_w_valid,
    input  logic                       b_valid,
    input  logic                       b_ready,
    input  logic                       r_valid,
    input  logic                       r_ready,
    input  logic                       r_last,
    output logic                       write_sel,
    output logic                       read_sel
);

    localparam logic [`AXI_ADDR_WIDTH-1:0] WIN_LO = `AXI_ADDR_WIDTH'(`REG_BASE);
    localparam logic [`AXI_ADDR_WIDTH-1:0] WIN_HI = `AXI_ADDR_WIDTH'(`REG_BASE + 4 * `REG_COUNT);

    logic aw_hit, ar_hit;
    logic write_open, read_open;

    assign aw_hit = (aw_addr >= WIN_LO) && (aw_addr < WIN_HI);
    assign ar_hit = (ar_addr >= WIN_LO) && (ar_addr < WIN_HI);

    // A new address is only offered while its direction is closed
    assign reg_aw_valid  = aw_valid && !write_open && aw_hit;
    assign term_aw_valid = aw_valid && !write_open && !aw_hit;
    assign aw_ready      = !write_open && (aw_hit ? reg_aw_ready : term_aw_ready);
    assign reg_ar_valid  = ar_valid && !read_open && ar_hit;
    assign term_ar_valid = ar_valid && !read_open && !ar_hit;
    assign ar_ready      = !read_open && (ar_hit ? reg_ar_ready : term_ar_ready);

    assign reg_w_valid  = w_valid && write_open && !write_sel;
    assign term_w_valid = w_valid && write_open && write_sel;

    // Select is high when the terminator owns the transaction
    always_ff @(posedge clock) begin
        if (!reset) begin
            write_open <= 1'b0;
            write_sel  <= 1'b0;
            read_open  <= 1'b0;
            read_sel   <= 1'b0;
        end else begin
            if (aw_valid && aw_ready) begin
                write_open <= 1'b1;
                write_sel  <= !aw_hit;
            end else if (b_valid && b_ready) begin
                write_open <= 1'b0;
            end
            if (ar_valid && ar_ready) begin
                read_open <= 1'b1;
                read_sel  <= !ar_hit;
            end else if (r_valid && r_ready && r_last) begin
                read_open <= 1'b0;
            end
        end
    end

    // A target answers only while its direction is open
    a_response_open: assert property (@(posedge clock) disable iff (!reset)
        (!b_valid || write_open) && (!r_valid || read_open));

endmodule

`default_nettype wire

//--- hdl/axi_register_bank.sv
/* Register bank target. Carries out INCR write and read bursts on a small array of
   32-bit registers, with byte strobes and SLVERR for beats past the last register. */
`timescale 1ns/1ps
`default_nettype none

`include "axi_slave_config.svh"

module axi_register_bank (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         aw_valid,
    output logic                         aw_ready,
    input  logic [`AXI_ID_WIDTH-1:0]     aw_id,
    input  logic [`AXI_ADDR_WIDTH-1:0]   aw_addr,
    input  logic [`AXI_LEN_WIDTH-1:0]    aw_len,
    input  logic                         w_valid,
    output logic                         w_ready,
    input  logic [`AXI_DATA_WIDTH-1:0]   w_data,
    input  logic [`AXI_DATA_WIDTH/8-1:0] w_strb,
    input  logic                         w_last,
    output logic                         b_valid,
    input  logic                         b_ready,
    output logic [`AXI_ID_WIDTH-1:0]     b_id,
    output logic [1:0]                   b_resp,
    input  logic                         ar_valid,
    output logic                         ar_ready,
    input  logic [`AXI_ID_WIDTH-1:0]     ar_id,
    input  logic [`AXI_ADDR_WIDTH-1:0]   ar_addr,
    input  logic [`AXI_LEN_WIDTH-1:0]    ar_len,
    output logic                         r_valid,
    input  logic                         r_ready,
    output logic [`AXI_ID_WIDTH-1:0]     r_id,
    output logic [`AXI_DATA_WIDTH-1:0]   r_data,
    output logic [1:0]                   r_resp,
    output logic                         r_last
);

    localparam int IDX_W = `AXI_ADDR_WIDTH - 2;
    localparam int SEL_W = $clog2(`REG_COUNT);
    localparam logic [`AXI_ADDR_WIDTH-1:0] BASE = `AXI_ADDR_WIDTH'(`REG_BASE);

    logic [`AXI_DATA_WIDTH-1:0] regs [`REG_COUNT];
    logic [`AXI_ADDR_WIDTH-1:0] aw_rel;
    logic [`AXI_ADDR_WIDTH-1:0] ar_rel;
    logic [IDX_W-1:0]           w_index, r_index, rd_index;
    logic [`AXI_LEN_WIDTH-1:0]  w_left, r_left, rd_left;
    logic                       write_err, w_fire, w_hit;
    logic                       ar_fire, r_fire, rd_load, rd_hit;

    assign aw_rel = aw_addr - BASE;
    assign ar_rel = ar_addr - BASE;
    assign w_fire = w_valid && w_ready;
    assign w_hit  = w_index < IDX_W'(`REG_COUNT);

    // Next read beat comes from the AR address or from the previous beat
    assign ar_fire  = ar_valid && ar_ready;
    assign r_fire   = r_valid && r_ready;
    assign rd_load  = ar_fire || (r_fire && !r_last);
    assign rd_index = ar_fire ? ar_rel[`AXI_ADDR_WIDTH-1:2] : r_index + 1'b1;
    assign rd_left  = ar_fire ? ar_len : r_left - 1'b1;
    assign rd_hit   = rd_index < IDX_W'(`REG_COUNT);

    assign b_resp = write_err ? axi_slave_pkg::RESP_SLVERR : axi_slave_pkg::RESP_OKAY;

    always_ff @(posedge clock) begin
        if (!reset) begin
            aw_ready <= 1'b0;
            w_ready  <= 1'b0;
            b_valid  <= 1'b0;
            ar_ready <= 1'b0;
            r_valid  <= 1'b0;
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // The bank stays closed to AW until the B response is taken
            aw_ready <= aw_valid && !aw_ready && !w_ready && !b_valid;
            if (aw_valid && aw_ready) begin
                w_ready <= 1'b1;
            end else if (w_fire && w_last) begin
                w_ready <= 1'b0;
            end
            if (w_fire && w_last) begin
                b_valid <= 1'b1;
            end else if (b_valid && b_ready) begin
                b_valid <= 1'b0;
            end
            if (w_fire && w_hit) begin
                for (int b = 0; b < `AXI_DATA_WIDTH / 8; b++) begin
                    if (w_strb[b]) begin
                        regs[w_index[SEL_W-1:0]][8*b +: 8] <= w_data[8*b +: 8];
                    end
                end
            end

            ar_ready <= ar_valid && !ar_ready && !r_valid;
            if (rd_load) begin
                r_valid <= 1'b1;
            end else if (r_fire) begin
                r_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (aw_valid && aw_ready) begin
            b_id      <= aw_id;
            w_index   <= aw_rel[`AXI_ADDR_WIDTH-1:2];
            w_left    <= aw_len;
            write_err <= 1'b0;
        end else if (w_fire) begin
            w_index <= w_index + 1'b1;
            w_left  <= w_left - 1'b1;
            if (!w_hit) begin
                write_err <= 1'b1;
            end
        end
        if (ar_fire) begin
            r_id <= ar_id;
        end
        if (rd_load) begin
            r_index <= rd_index;
            r_left  <= rd_left;
            r_last  <= rd_left == '0;
            r_data  <= rd_hit ? regs[rd_index[SEL_W-1:0]] : '0;
            r_resp  <= rd_hit ? axi_slave_pkg::RESP_OKAY : axi_slave_pkg::RESP_SLVERR;
        end
    end

    a_w_last_on_len: assert property (@(posedge clock) disable iff (!reset)
        w_fire |-> (w_last == (w_left == '0)));

    a_r_stable: assert property (@(posedge clock) disable iff (!reset)
        r_valid && !r_ready |=> r_valid && $stable({r_id, r_data, r_resp, r_last}));

endmodule

`default_nettype wire

//--- hdl/axi_response_mux.sv
/* Result stage for one response channel. Passes the selected target's valid and payload
   to the manager and returns the manager's ready to that target only. */
`timescale 1ns/1ps
`default_nettype none

module axi_response_mux #(
    parameter type payload_t = logic
) (
    input  logic     sel,
    input  logic     a_valid,
    input  payload_t a_payload,
    output logic     a_ready,
    input  logic     b_valid,
    input  payload_t b_payload,
    output logic     b_ready,
    output logic     out_valid,
    output payload_t out_payload,
    input  logic     out_ready
);

    // Input a is the register bank and input b the terminator
    assign out_valid   = sel ? b_valid : a_valid;
    assign out_payload = sel ? b_payload : a_payload;
    assign a_ready     = out_ready && !sel;
    assign b_ready     = out_ready && sel;

endmodule

`default_nettype wire

//--- hdl/axi_slave_config.svh
/* Widths, register count and register window base for the AXI slave endpoint.
   Included by every file that sizes an AXI port or decodes an address. */
`ifndef AXI_SLAVE_CONFIG_SVH
`define AXI_SLAVE_CONFIG_SVH

`define AXI_ID_WIDTH 4
`define AXI_ADDR_WIDTH 16
`define AXI_DATA_WIDTH 32

// Number of beats in a burst is this field plus one
`define AXI_LEN_WIDTH 8

`define REG_COUNT 16
`define REG_BASE 'h1000

`endif

//--- hdl/axi_slave_pkg.sv
/* Response code and response payload types shared by the targets and the result stage. */
`default_nettype none

`include "axi_slave_config.svh"

package axi_slave_pkg;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'd0,
        RESP_SLVERR = 2'd2,
        RESP_DECERR = 2'd3
    } resp_t;

    // Payload of the B channel
    typedef struct packed {
        logic [`AXI_ID_WIDTH-1:0] id;
        resp_t                    resp;
    } write_resp_t;

    // Payload of one R beat
    typedef struct packed {
        logic [`AXI_ID_WIDTH-1:0]   id;
        logic [`AXI_DATA_WIDTH-1:0] data;
        resp_t                      resp;
        logic                       last;
    } read_beat_t;

endpackage

`default_nettype wire

//--- hdl/axi_slave_subsystem.sv
/* Top level of the AXI slave endpoint. One manager port feeds the address decode, the
   register bank and the terminator, and two response muxes return B and R. */
`timescale 1ns/1ps
`default_nettype none

`include "axi_slave_config.svh"

module axi_slave_subsystem (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         aw_valid,
    output logic                         aw_ready,
    input  logic [`AXI_ID_WIDTH-1:0]     aw_id,
    input  logic [`AXI_ADDR_WIDTH-1:0]   aw_addr,
    input  logic [`AXI_LEN_WIDTH-1:0]    aw_len,
    input  logic                         w_valid,
    output logic                         w_ready,
    input  logic [`AXI_DATA_WIDTH-1:0]   w_data,
    input  logic [`AXI_DATA_WIDTH/8-1:0] w_strb,
    input  logic                         w_last,
    output logic                         b_valid,
    input  logic                         b_ready,
    output logic [`AXI_ID_WIDTH-1:0]     b_id,
    output logic [1:0]                   b_resp,
    input  logic                         ar_valid,
    output logic                         ar_ready,
    input  logic [`AXI_ID_WIDTH-1:0]     ar_id,
    input  logic [`AXI_ADDR_WIDTH-1:0]   ar_addr,
    input  logic [`AXI_LEN_WIDTH-1:0]    ar_len,
    output logic                         r_valid,
    input  logic                         r_ready,
    output logic [`AXI_ID_WIDTH-1:0]     r_id,
    output logic [`AXI_DATA_WIDTH-1:0]   r_data,
    output logic [1:0]                   r_resp,
    output logic                         r_last
);

    logic reg_aw_valid, reg_aw_ready, term_aw_valid, term_aw_ready;
    logic reg_ar_valid, reg_ar_ready, term_ar_valid, term_ar_ready;
    logic reg_w_valid, reg_w_ready, term_w_valid, term_w_ready;
    logic reg_b_valid, reg_b_ready, term_b_valid, term_b_ready;
    logic reg_r_valid, reg_r_ready, term_r_valid, term_r_ready;
    logic reg_r_last, term_r_last, write_sel, read_sel;
    logic [`AXI_ID_WIDTH-1:0]   reg_b_id, term_b_id, reg_r_id, term_r_id;
    logic [1:0]                 reg_b_resp, term_b_resp, reg_r_resp, term_r_resp;
    logic [`AXI_DATA_WIDTH-1:0] reg_r_data, term_r_data;

    axi_slave_pkg::write_resp_t reg_b_payload, term_b_payload, b_payload;
    axi_slave_pkg::read_beat_t  reg_r_payload, term_r_payload, r_payload;

    // Only the target that holds the write raises its w_ready
    assign w_ready = write_sel ? term_w_ready : reg_w_ready;

    axi_address_decode decode0 (
        .clock(clock), .reset(reset),
        .aw_valid(aw_valid), .aw_addr(aw_addr), .aw_ready(aw_ready),
        .ar_valid(ar_valid), .ar_addr(ar_addr), .ar_ready(ar_ready),
        .reg_aw_valid(reg_aw_valid), .term_aw_valid(term_aw_valid),
        .reg_aw_ready(reg_aw_ready), .term_aw_ready(term_aw_ready),
        .reg_ar_valid(reg_ar_valid), .term_ar_valid(term_ar_valid),
        .reg_ar_ready(reg_ar_ready), .term_ar_ready(term_ar_ready),
        .w_valid(w_valid), .reg_w_valid(reg_w_valid), .term_w_valid(term_w_valid),
        .b_valid(b_valid), .b_ready(b_ready),
        .r_valid(r_valid), .r_ready(r_ready), .r_last(r_last),
        .write_sel(write_sel), .read_sel(read_sel)
    );

    axi_register_bank bank0 (
        .clock(clock), .reset(reset),
        .aw_valid(reg_aw_valid), .aw_ready(reg_aw_ready),
        .aw_id(aw_id), .aw_addr(aw_addr), .aw_len(aw_len),
        .w_valid(reg_w_valid), .w_ready(reg_w_ready),
        .w_data(w_data), .w_strb(w_strb), .w_last(w_last),
        .b_valid(reg_b_valid), .b_ready(reg_b_ready), .b_id(reg_b_id), .b_resp(reg_b_resp),
        .ar_valid(reg_ar_valid), .ar_ready(reg_ar_ready),
        .ar_id(ar_id), .ar_addr(ar_addr), .ar_len(ar_len),
        .r_valid(reg_r_valid), .r_ready(reg_r_ready), .r_id(reg_r_id),
        .r_data(reg_r_data), .r_resp(reg_r_resp), .r_last(reg_r_last)
    );

    axi_terminator term0 (
        .clock(clock), .reset(reset),
        .aw_valid(term_aw_valid), .aw_ready(term_aw_ready),
        .aw_id(aw_id), .aw_addr(aw_addr), .aw_len(aw_len),
        .w_valid(term_w_valid), .w_ready(term_w_ready), .w_last(w_last),
        .b_valid(term_b_valid), .b_ready(term_b_ready), .b_id(term_b_id), .b_resp(term_b_resp),
        .ar_valid(term_ar_valid), .ar_ready(term_ar_ready),
        .ar_id(ar_id), .ar_addr(ar_addr), .ar_len(ar_len),
        .r_valid(term_r_valid), .r_ready(term_r_ready), .r_id(term_r_id),
        .r_data(term_r_data), .r_resp(term_r_resp), .r_last(term_r_last)
    );

    assign reg_b_payload  = {reg_b_id, reg_b_resp};
    assign term_b_payload = {term_b_id, term_b_resp};
    assign reg_r_payload  = {reg_r_id, reg_r_data, reg_r_resp, reg_r_last};
    assign term_r_payload = {term_r_id, term_r_data, term_r_resp, term_r_last};

    axi_response_mux #(.payload_t(axi_slave_pkg::write_resp_t)) b_mux0 (
        .sel(write_sel),
        .a_valid(reg_b_valid), .a_payload(reg_b_payload), .a_ready(reg_b_ready),
        .b_valid(term_b_valid), .b_payload(term_b_payload), .b_ready(term_b_ready),
        .out_valid(b_valid), .out_payload(b_payload), .out_ready(b_ready)
    );

    axi_response_mux #(.payload_t(axi_slave_pkg::read_beat_t)) r_mux0 (
        .sel(read_sel),
        .a_valid(reg_r_valid), .a_payload(reg_r_payload), .a_ready(reg_r_ready),
        .b_valid(term_r_valid), .b_payload(term_r_payload), .b_ready(term_r_ready),
        .out_valid(r_valid), .out_payload(r_payload), .out_ready(r_ready)
    );

    assign b_id   = b_payload.id;
    assign b_resp = b_payload.resp;
    assign r_id   = r_payload.id;
    assign r_data = r_payload.data;
    assign r_resp = r_payload.resp;
    assign r_last = r_payload.last;

endmodule

`default_nettype wire

//--- hdl/axi_terminator.sv
/* Target for unmapped addresses. Swallows write data up to WLAST and answers DECERR,
   and returns zero read beats with DECERR. Serves one direction at a time. */
`timescale 1ns/1ps
`default_nettype none

`include "axi_slave_config.svh"

module axi_terminator (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       aw_valid,
    output logic                       aw_ready,
    input  logic [`AXI_ID_WIDTH-1:0]   aw_id,
    input  logic [`AXI_ADDR_WIDTH-1:0] aw_addr,
    input  logic [`AXI_LEN_WIDTH-1:0]  aw_len,
    input  logic                       w_valid,
    output logic                       w_ready,
    input  logic                       w_last,
    output logic                       b_valid,
    input  logic                       b_ready,
    output logic [`AXI_ID_WIDTH-1:0]   b_id,
    output logic [1:0]                 b_resp,
    input  logic                       ar_valid,
    output logic                       ar_ready,
    input  logic [`AXI_ID_WIDTH-1:0]   ar_id,
    input  logic [`AXI_ADDR_WIDTH-1:0] ar_addr,
    input  logic [`AXI_LEN_WIDTH-1:0]  ar_len,
    output logic                       r_valid,
    input  logic                       r_ready,
    output logic [`AXI_ID_WIDTH-1:0]   r_id,
    output logic [`AXI_DATA_WIDTH-1:0] r_data,
    output logic [1:0]                 r_resp,
    output logic                       r_last
);

    logic                      write_open, read_open, idle;
    logic                      aw_start, ar_start, w_end, r_end;
    logic [`AXI_LEN_WIDTH-1:0] r_left;

    assign idle = !write_open && !read_open;

    // A write wins when both addresses arrive together
    assign aw_start = aw_valid && idle;
    assign ar_start = ar_valid && !aw_valid && idle;
    assign w_end    = w_valid && w_ready && w_last;
    assign r_end    = r_valid && r_ready && r_last;

    assign b_resp = axi_slave_pkg::RESP_DECERR;
    assign r_resp = axi_slave_pkg::RESP_DECERR;
    assign r_data = '0;

    always_ff @(posedge clock) begin
        if (!reset) begin
            write_open <= 1'b0;
            read_open  <= 1'b0;
            aw_ready   <= 1'b0;
            w_ready    <= 1'b0;
            b_valid    <= 1'b0;
            ar_ready   <= 1'b0;
            r_valid    <= 1'b0;
        end else begin
            aw_ready <= aw_start;
            ar_ready <= ar_start;
            // Flags rise with the ready pulse so the other direction is locked out at once
            if (aw_start) begin
                write_open <= 1'b1;
            end else if (b_valid && b_ready) begin
                write_open <= 1'b0;
            end
            if (ar_start) begin
                read_open <= 1'b1;
            end else if (r_end) begin
                read_open <= 1'b0;
            end
            if (aw_valid && aw_ready) begin
                w_ready <= 1'b1;
            end else if (w_end) begin
                w_ready <= 1'b0;
            end
            if (w_end) begin
                b_valid <= 1'b1;
            end else if (b_valid && b_ready) begin
                b_valid <= 1'b0;
            end
            if (ar_valid && ar_ready) begin
                r_valid <= 1'b1;
            end else if (r_end) begin
                r_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (aw_valid && aw_ready) begin
            b_id <= aw_id;
        end
        if (ar_valid && ar_ready) begin
            r_id   <= ar_id;
            r_left <= ar_len;
            r_last <= ar_len == '0;
        end else if (r_valid && r_ready && !r_last) begin
            r_left <= r_left - 1'b1;
            r_last <= r_left == `AXI_LEN_WIDTH'(1);
        end
    end

    // Write data or a write response never overlaps a read beat
    a_one_direction: assert property (@(posedge clock) disable iff (!reset)
        !((w_ready || b_valid) && r_valid));

endmodule

`default_nettype wire

//--- tb/tb_axi_slave_subsystem.sv
/* Testbench for the AXI slave endpoint. Applies a table of write and read bursts with
   random B and R back-pressure and checks every response against a register model. */
`timescale 1ns/1ps
`default_nettype none

`include "axi_slave_config.svh"

module tb_axi_slave_subsystem;

    localparam int NUM_TX = 16;

    typedef struct packed {
        logic                         is_write;
        logic [`AXI_ID_WIDTH-1:0]     id;
        logic [`AXI_ADDR_WIDTH-1:0]   addr;
        logic [`AXI_LEN_WIDTH-1:0]    len;
        logic [`AXI_DATA_WIDTH/8-1:0] strb;
        axi_slave_pkg::resp_t         resp;
    } txn_t;

    logic                         clock, reset;
    logic                         aw_valid, aw_ready, w_valid, w_ready, w_last;
    logic                         b_valid, b_ready, ar_valid, ar_ready;
    logic                         r_valid, r_ready, r_last;
    logic [`AXI_ID_WIDTH-1:0]     aw_id, b_id, ar_id, r_id;
    logic [`AXI_ADDR_WIDTH-1:0]   aw_addr, ar_addr;
    logic [`AXI_LEN_WIDTH-1:0]    aw_len, ar_len;
    logic [`AXI_DATA_WIDTH-1:0]   w_data, r_data;
    logic [`AXI_DATA_WIDTH/8-1:0] w_strb;
    logic [1:0]                   b_resp, r_resp;

    txn_t                       txns [NUM_TX];
    logic [`AXI_DATA_WIDTH-1:0] model [`REG_COUNT];
    logic [15:0]                lfsr_state;
    int                         cycles = 0;
    int                         cycle_limit = 0;
    int                         total_beats;

    axi_slave_subsystem dut0 (
        .clock(clock), .reset(reset),
        .aw_valid(aw_valid), .aw_ready(aw_ready), .aw_id(aw_id), .aw_addr(aw_addr),
        .aw_len(aw_len),
        .w_valid(w_valid), .w_ready(w_ready), .w_data(w_data), .w_strb(w_strb),
        .w_last(w_last),
        .b_valid(b_valid), .b_ready(b_ready), .b_id(b_id), .b_resp(b_resp),
        .ar_valid(ar_valid), .ar_ready(ar_ready), .ar_id(ar_id), .ar_addr(ar_addr),
        .ar_len(ar_len),
        .r_valid(r_valid), .r_ready(r_ready), .r_id(r_id), .r_data(r_data),
        .r_resp(r_resp), .r_last(r_last)
    );

    always #2 clock = ~clock;

    // A hung handshake stops the run here
    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("Timeout: the DUT did not finish the table within %0d cycles", cycle_limit);
            $display("Verification failed");
            $fatal(1);
        end
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, expected);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    // Fibonacci LFSR with taps 16, 14, 13 and 11
    function automatic logic take_bit();
        logic feedback;
        feedback = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], feedback};
        return feedback;
    endfunction

    function automatic logic [`AXI_DATA_WIDTH-1:0] random_word();
        logic [`AXI_DATA_WIDTH-1:0] word;
        for (int i = 0; i < `AXI_DATA_WIDTH; i++) begin
            word[i] = take_bit();
        end
        return word;
    endfunction

    // Register number reached by a beat, negative below the window
    function automatic int word_index(input logic [`AXI_ADDR_WIDTH-1:0] addr, input int beat);
        return (int'(addr) - int'(`REG_BASE)) / 4 + beat;
    endfunction

    function automatic txn_t make_txn(input logic is_write, input int id, input int addr,
                                      input int len, input int strb,
                                      input axi_slave_pkg::resp_t resp);
        txn_t t;
        t.is_write = is_write;
        t.id       = id[`AXI_ID_WIDTH-1:0];
        t.addr     = addr[`AXI_ADDR_WIDTH-1:0];
        t.len      = len[`AXI_LEN_WIDTH-1:0];
        t.strb     = strb[`AXI_DATA_WIDTH/8-1:0];
        t.resp     = resp;
        return t;
    endfunction

    task automatic fill_table();
        // Single write and read back, then partial strobes on one register
        txns[0]  = make_txn(1'b1, 3, 'h1000, 0, 'hF, axi_slave_pkg::RESP_OKAY);
        txns[1]  = make_txn(1'b0, 5, 'h1000, 0, 'h0, axi_slave_pkg::RESP_OKAY);
        txns[2]  = make_txn(1'b1, 1, 'h1004, 0, 'h5, axi_slave_pkg::RESP_OKAY);
        txns[3]  = make_txn(1'b1, 2, 'h1004, 0, 'h8, axi_slave_pkg::RESP_OKAY);
        txns[4]  = make_txn(1'b0, 6, 'h1004, 0, 'h0, axi_slave_pkg::RESP_OKAY);
        // INCR bursts, the last pair runs past register 15
        txns[5]  = make_txn(1'b1, 7, 'h1010, 3, 'hF, axi_slave_pkg::RESP_OKAY);
        txns[6]  = make_txn(1'b0, 8, 'h100C, 5, 'h0, axi_slave_pkg::RESP_OKAY);
        txns[7]  = make_txn(1'b1, 9, 'h1038, 3, 'hF, axi_slave_pkg::RESP_SLVERR);
        txns[8]  = make_txn(1'b0, 10, 'h1038, 3, 'h0, axi_slave_pkg::RESP_SLVERR);
        // Unmapped accesses on both sides of the window
        txns[9]  = make_txn(1'b1, 11, 'h2000, 2, 'hF, axi_slave_pkg::RESP_DECERR);
        txns[10] = make_txn(1'b1, 12, 'h0FFC, 0, 'hF, axi_slave_pkg::RESP_DECERR);
        txns[11] = make_txn(1'b0, 13, 'h0040, 3, 'h0, axi_slave_pkg::RESP_DECERR);
        txns[12] = make_txn(1'b0, 14, 'h1040, 1, 'h0, axi_slave_pkg::RESP_DECERR);
        txns[13] = make_txn(1'b0, 15, 'h1000, 15, 'h0, axi_slave_pkg::RESP_OKAY);
        txns[14] = make_txn(1'b1, 4, 'h1020, 7, 'h3, axi_slave_pkg::RESP_OKAY);
        txns[15] = make_txn(1'b0, 0, 'h1020, 7, 'h0, axi_slave_pkg::RESP_OKAY);
    endtask

    // Called and returns just after a falling edge
    task automatic run_write(input txn_t t);
        int                         idx;
        int                         lane;
        logic [`AXI_DATA_WIDTH-1:0] data;
        logic                       held;
        logic                       done;
        logic [`AXI_ID_WIDTH-1:0]   held_id;
        logic [1:0]                 held_resp;
        aw_valid = 1'b1;
        aw_id    = t.id;
        aw_addr  = t.addr;
        aw_len   = t.len;
        do begin
            @(posedge clock);
        end while (aw_ready !== 1'b1);
        @(negedge clock);
        aw_valid = 1'b0;
        for (int beat = 0; beat <= int'(t.len); beat++) begin
            data    = random_word();
            w_valid = 1'b1;
            w_data  = data;
            w_strb  = t.strb;
            w_last  = beat == int'(t.len);
            idx     = word_index(t.addr, beat);
            if (t.resp != axi_slave_pkg::RESP_DECERR && idx >= 0 && idx < `REG_COUNT) begin
                for (lane = 0; lane < `AXI_DATA_WIDTH / 8; lane++) begin
                    if (t.strb[lane]) begin
                        model[idx][8*lane +: 8] = data[8*lane +: 8];
                    end
                end
            end
            do begin
                @(posedge clock);
            end while (w_ready !== 1'b1);
            @(negedge clock);
        end
        w_valid = 1'b0;
        w_last  = 1'b0;
        held    = 1'b0;
        done    = 1'b0;
        while (!done) begin
            b_ready = take_bit();
            @(posedge clock);
            if (held) begin
                check_value("b_valid held", b_valid, 1);
                check_value("b_id held", b_id, held_id);
                check_value("b_resp held", b_resp, held_resp);
            end
            if (b_valid && b_ready) begin
                check_value("b_id", b_id, t.id);
                check_value("b_resp", b_resp, t.resp);
                done = 1'b1;
            end else begin
                held      = b_valid;
                held_id   = b_id;
                held_resp = b_resp;
            end
            @(negedge clock);
        end
        b_ready = 1'b0;
        check_value("b_valid after B", b_valid, 0);
    endtask

    task automatic run_read(input txn_t t);
        int                         beat;
        int                         idx;
        logic                       held;
        logic [`AXI_ID_WIDTH-1:0]   held_id;
        logic [`AXI_DATA_WIDTH-1:0] held_data;
        logic [1:0]                 held_resp;
        logic                       held_last;
        logic [`AXI_DATA_WIDTH-1:0] exp_data;
        logic [1:0]                 exp_resp;
        ar_valid = 1'b1;
        ar_id    = t.id;
        ar_addr  = t.addr;
        ar_len   = t.len;
        do begin
            @(posedge clock);
        end while (ar_ready !== 1'b1);
        @(negedge clock);
        ar_valid = 1'b0;
        beat     = 0;
        held     = 1'b0;
        while (beat <= int'(t.len)) begin
            r_ready = take_bit();
            @(posedge clock);
            if (held) begin
                check_value("r_valid held", r_valid, 1);
                check_value("r_id held", r_id, held_id);
                check_value("r_data held", r_data, held_data);
                check_value("r_resp held", r_resp, held_resp);
                check_value("r_last held", r_last, held_last);
            end
            if (r_valid && r_ready) begin
                idx = word_index(t.addr, beat);
                if (t.resp == axi_slave_pkg::RESP_DECERR) begin
                    exp_data = '0;
                    exp_resp = axi_slave_pkg::RESP_DECERR;
                end else if (idx >= 0 && idx < `REG_COUNT) begin
                    exp_data = model[idx];
                    exp_resp = axi_slave_pkg::RESP_OKAY;
                end else begin
                    exp_data = '0;
                    exp_resp = axi_slave_pkg::RESP_SLVERR;
                end
                check_value("r_id", r_id, t.id);
                check_value("r_data", r_data, exp_data);
                check_value("r_resp", r_resp, exp_resp);
                check_value("r_last", r_last, beat == int'(t.len));
                beat++;
                held = 1'b0;
            end else begin
                held      = r_valid;
                held_id   = r_id;
                held_data = r_data;
                held_resp = r_resp;
                held_last = r_last;
            end
            @(negedge clock);
        end
        r_ready = 1'b0;
        check_value("r_valid after r_last", r_valid, 0);
    endtask

    initial begin
        clock      = 1'b0;
        reset      = 1'b0;
        aw_valid   = 1'b0;
        aw_id      = '0;
        aw_addr    = '0;
        aw_len     = '0;
        w_valid    = 1'b0;
        w_data     = '0;
        w_strb     = '0;
        w_last     = 1'b0;
        b_ready    = 1'b0;
        ar_valid   = 1'b0;
        ar_id      = '0;
        ar_addr    = '0;
        ar_len     = '0;
        r_ready    = 1'b0;
        lfsr_state = 16'd93;
        for (int i = 0; i < `REG_COUNT; i++) begin
            model[i] = '0;
        end
        fill_table();
        total_beats = 0;
        for (int i = 0; i < NUM_TX; i++) begin
            total_beats += int'(txns[i].len) + 1;
        end
        // Every beat may wait on back-pressure, plus handshake overhead per transaction
        cycle_limit = 10 + NUM_TX * 16 + total_beats * 8;
        repeat (10) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;
        check_value("aw_ready", aw_ready, 0);
        check_value("w_ready", w_ready, 0);
        check_value("b_valid", b_valid, 0);
        check_value("ar_ready", ar_ready, 0);
        check_value("r_valid", r_valid, 0);
        for (int i = 0; i < NUM_TX; i++) begin
            if (txns[i].is_write) begin
                run_write(txns[i]);
            end else begin
                run_read(txns[i]);
            end
        end
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire
